/* source/mem_cfg_pkg.sv */
/* memory port configuration
 * widths and limits shared by the read engine, the write engine and the bus arbiter */
package mem_cfg_pkg;

    localparam int addr_w          = 32;
    localparam int data_w          = 32;
    localparam int bytes_per_dword = 4;
    localparam int dword_addr_w    = 30;
    localparam int off_w           = addr_w - dword_addr_w;    // byte offset in a dword

    localparam int max_read_bytes  = 8;
    localparam int max_write_bytes = 4;
    localparam int max_read_beats  = 3;
    localparam int burst_w         = 2;
    localparam int read_len_w      = 4;
    localparam int write_len_w     = 3;

    //--------------------------------------------------
    // derived widths
    localparam int read_data_w  = max_read_bytes * 8;
    localparam int write_data_w = max_write_bytes * 8;
    localparam int coll_w       = max_read_beats * data_w;  // read collector
    localparam int lane_w       = 2 * data_w;               // write may straddle two dwords
    localparam int be_pair_w    = 2 * bytes_per_dword;
    localparam int write_span_w = write_len_w + 1;

    // rounding terms for the dword count
    localparam logic [read_len_w-1:0] read_round  = read_len_w'(bytes_per_dword - 1);
    localparam logic [write_len_w:0]  write_round = write_span_w'(bytes_per_dword - 1);
    localparam logic [burst_w-1:0]    beats_full  = burst_w'(max_read_beats);
    localparam logic [burst_w-1:0]    one_beat    = burst_w'(1);

endpackage

/* source/mem_bus_pkg.sv */
/* memory port bus types
 * command and response records between the engines and the arbiter, plus the FSM states */
package mem_bus_pkg;

    //--------------------------------------------------
    // engine command is valid while read or write is set
    typedef struct packed {
        logic                                    read;
        logic                                    write;
        logic [mem_cfg_pkg::dword_addr_w-1:0]    address;      // burst start dword
        logic [mem_cfg_pkg::burst_w-1:0]         burstcount;
        logic [mem_cfg_pkg::bytes_per_dword-1:0] byteenable;
        logic [mem_cfg_pkg::data_w-1:0]          writedata;
    } bus_cmd_t;

    // response back to an engine
    typedef struct packed {
        logic                           accept;     // command or write beat taken
        logic                           valid;      // read beat present
        logic                           last;       // final beat of the burst
        logic [mem_cfg_pkg::data_w-1:0] data;
    } bus_rsp_t;

    //--------------------------------------------------
    typedef enum logic [1:0] {
        rd_idle,
        rd_request,
        rd_collect,
        rd_finish
    } rd_state_e;

    typedef enum logic [1:0] {
        wr_idle,
        wr_beat,
        wr_finish
    } wr_state_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_read_cmd,
        arb_read_data,
        arb_write
    } arb_state_e;

    typedef enum logic {
        owner_read,
        owner_write
    } owner_e;

endpackage

/* source/memory_read.sv */
/* memory read engine
 * issues one dword read burst per request and returns the bytes aligned to the address */
`timescale 1ns/1ps

module memory_read (
    input  logic                                clk,
    input  logic                                arst_n,

    input  logic                                read_do,
    input  logic [mem_cfg_pkg::addr_w-1:0]      read_address,
    input  logic [mem_cfg_pkg::read_len_w-1:0]  read_length,
    output logic                                read_done,
    output logic [mem_cfg_pkg::read_data_w-1:0] read_data,

    output mem_bus_pkg::bus_cmd_t               cmd,
    input  mem_bus_pkg::bus_rsp_t               rsp
);

mem_bus_pkg::rd_state_e state_q;

logic [mem_cfg_pkg::addr_w-1:0]      addr_q;
logic [mem_cfg_pkg::read_len_w-1:0]  len_q;
logic [mem_cfg_pkg::burst_w-1:0]     beats_q;
logic [mem_cfg_pkg::coll_w-1:0]      coll_q;    // beats shift in from the top

logic [mem_cfg_pkg::read_len_w-1:0]  span;
logic [mem_cfg_pkg::burst_w+mem_cfg_pkg::off_w+2:0] shift_bits;
logic [mem_cfg_pkg::coll_w-1:0]      aligned;
logic [mem_cfg_pkg::read_data_w-1:0] byte_mask;

//--------------------------------------------------
// dword count and byte alignment
always_comb begin
    span = {{(mem_cfg_pkg::read_len_w - mem_cfg_pkg::off_w){1'b0}},
            read_address[mem_cfg_pkg::off_w-1:0]}
           + read_length + mem_cfg_pkg::read_round;

    // skip the unused collector slots, then the start offset
    shift_bits = {mem_cfg_pkg::beats_full - beats_q, addr_q[mem_cfg_pkg::off_w-1:0], 3'b000};
    aligned    = coll_q >> shift_bits;
    byte_mask  = ~({mem_cfg_pkg::read_data_w{1'b1}} << {len_q, 3'b000});
end

always_comb begin
    cmd            = '0;
    cmd.read       = (state_q == mem_bus_pkg::rd_request);
    cmd.address    = addr_q[mem_cfg_pkg::addr_w-1:mem_cfg_pkg::off_w];
    cmd.burstcount = beats_q;
    cmd.byteenable = '1;    // whole dwords
end

//--------------------------------------------------
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state_q   <= mem_bus_pkg::rd_idle;
        read_done <= 1'b0;
    end else begin
        read_done <= 1'b0;
        case (state_q)
            mem_bus_pkg::rd_idle: begin
                if (read_do) begin
                    state_q <= mem_bus_pkg::rd_request;
                end
            end
            mem_bus_pkg::rd_request: begin
                if (rsp.accept) begin
                    state_q <= mem_bus_pkg::rd_collect;
                end
            end
            mem_bus_pkg::rd_collect: begin
                if (rsp.last) begin
                    state_q <= mem_bus_pkg::rd_finish;
                end
            end
            mem_bus_pkg::rd_finish: begin
                read_done <= 1'b1;
                state_q   <= mem_bus_pkg::rd_idle;
            end
            default: state_q <= mem_bus_pkg::rd_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state_q == mem_bus_pkg::rd_idle && read_do) begin
        addr_q  <= read_address;
        len_q   <= read_length;
        beats_q <= span[mem_cfg_pkg::read_len_w-1:mem_cfg_pkg::off_w];
    end
    if (rsp.valid) begin
        coll_q <= {rsp.data, coll_q[mem_cfg_pkg::coll_w-1:mem_cfg_pkg::data_w]};
    end
    if (state_q == mem_bus_pkg::rd_finish) begin
        read_data <= aligned[mem_cfg_pkg::read_data_w-1:0] & byte_mask;
    end
end

endmodule

/* source/memory_write.sv */
/* memory write engine
 * splits a byte addressed write into one or two byte enabled dword beats */
`timescale 1ns/1ps

module memory_write (
    input  logic                                 clk,
    input  logic                                 arst_n,

    input  logic                                 write_do,
    input  logic [mem_cfg_pkg::addr_w-1:0]       write_address,
    input  logic [mem_cfg_pkg::write_len_w-1:0]  write_length,
    input  logic [mem_cfg_pkg::write_data_w-1:0] write_data,
    output logic                                 write_done,

    output mem_bus_pkg::bus_cmd_t                cmd,
    input  mem_bus_pkg::bus_rsp_t                rsp
);

mem_bus_pkg::wr_state_e state_q;
logic                   beat_q;     // second dword of the burst

logic [mem_cfg_pkg::dword_addr_w-1:0] dword_q;
logic [mem_cfg_pkg::burst_w-1:0]      beats_q;
logic [mem_cfg_pkg::lane_w-1:0]       lane_q;
logic [mem_cfg_pkg::be_pair_w-1:0]    be_q;

logic [mem_cfg_pkg::write_span_w-1:0] span;
logic [mem_cfg_pkg::lane_w-1:0]       lane_data;
logic [mem_cfg_pkg::be_pair_w-1:0]    lane_mask;
logic [mem_cfg_pkg::be_pair_w-1:0]    be_pair;

//--------------------------------------------------
// lane placement of the request
always_comb begin
    span = {{(mem_cfg_pkg::write_span_w - mem_cfg_pkg::off_w){1'b0}},
            write_address[mem_cfg_pkg::off_w-1:0]}
           + {1'b0, write_length} + mem_cfg_pkg::write_round;

    lane_data = {{mem_cfg_pkg::data_w{1'b0}}, write_data}
                << {write_address[mem_cfg_pkg::off_w-1:0], 3'b000};
    lane_mask = ~({mem_cfg_pkg::be_pair_w{1'b1}} << write_length);   // one bit per byte
    be_pair   = lane_mask << write_address[mem_cfg_pkg::off_w-1:0];
end

always_comb begin
    cmd            = '0;
    cmd.write      = (state_q == mem_bus_pkg::wr_beat);
    cmd.address    = dword_q;
    cmd.burstcount = beats_q;
    cmd.byteenable = beat_q ? be_q[mem_cfg_pkg::be_pair_w-1:mem_cfg_pkg::bytes_per_dword]
                            : be_q[mem_cfg_pkg::bytes_per_dword-1:0];
    cmd.writedata  = beat_q ? lane_q[mem_cfg_pkg::lane_w-1:mem_cfg_pkg::data_w]
                            : lane_q[mem_cfg_pkg::data_w-1:0];
end

//--------------------------------------------------
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state_q    <= mem_bus_pkg::wr_idle;
        beat_q     <= 1'b0;
        write_done <= 1'b0;
    end else begin
        write_done <= 1'b0;
        case (state_q)
            mem_bus_pkg::wr_idle: begin
                if (write_do) begin
                    state_q <= mem_bus_pkg::wr_beat;
                    beat_q  <= 1'b0;
                end
            end
            mem_bus_pkg::wr_beat: begin
                if (rsp.last) begin
                    state_q <= mem_bus_pkg::wr_finish;
                end else if (rsp.accept) begin
                    beat_q <= 1'b1;   // move on to the upper dword
                end
            end
            mem_bus_pkg::wr_finish: begin
                write_done <= 1'b1;
                state_q    <= mem_bus_pkg::wr_idle;
            end
            default: state_q <= mem_bus_pkg::wr_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state_q == mem_bus_pkg::wr_idle && write_do) begin
        dword_q <= write_address[mem_cfg_pkg::addr_w-1:mem_cfg_pkg::off_w];
        beats_q <= span[mem_cfg_pkg::write_span_w-1:mem_cfg_pkg::off_w];
        lane_q  <= lane_data;
        be_q    <= be_pair;
    end
end

endmodule

/* source/avalon_arbiter.sv */
/* Avalon master arbiter
 * grants the bus to one engine per burst, counts its beats and steers the responses back */
`timescale 1ns/1ps

module avalon_arbiter (
    input  logic                                    clk,
    input  logic                                    arst_n,

    input  mem_bus_pkg::bus_cmd_t                   read_cmd,
    input  mem_bus_pkg::bus_cmd_t                   write_cmd,
    output mem_bus_pkg::bus_rsp_t                   read_rsp,
    output mem_bus_pkg::bus_rsp_t                   write_rsp,

    output logic [mem_cfg_pkg::dword_addr_w-1:0]    avm_address,
    output logic [mem_cfg_pkg::burst_w-1:0]         avm_burstcount,
    output logic [mem_cfg_pkg::bytes_per_dword-1:0] avm_byteenable,
    output logic [mem_cfg_pkg::data_w-1:0]          avm_writedata,
    output logic                                    avm_read,
    output logic                                    avm_write,
    input  logic                                    avm_waitrequest,
    input  logic                                    avm_readdatavalid,
    input  logic [mem_cfg_pkg::data_w-1:0]          avm_readdata
);

mem_bus_pkg::arb_state_e state_q;
mem_bus_pkg::owner_e     owner_q;   // last owner, current owner while busy
mem_bus_pkg::owner_e     grant;
mem_bus_pkg::owner_e     owner;
mem_bus_pkg::bus_cmd_t   sel_cmd;

logic [mem_cfg_pkg::burst_w-1:0] burst_q;
logic [mem_cfg_pkg::burst_w-1:0] burst_len;
logic [mem_cfg_pkg::burst_w-1:0] beat_q;
logic                            accept;
logic                            beat_event;
logic                            last;

//--------------------------------------------------
// grant and command mux
always_comb begin
    if (read_cmd.read && write_cmd.write) begin
        grant = (owner_q == mem_bus_pkg::owner_read) ? mem_bus_pkg::owner_write
                                                     : mem_bus_pkg::owner_read;
    end else if (write_cmd.write) begin
        grant = mem_bus_pkg::owner_write;
    end else begin
        grant = mem_bus_pkg::owner_read;
    end

    owner   = (state_q == mem_bus_pkg::arb_idle) ? grant : owner_q;
    sel_cmd = (owner == mem_bus_pkg::owner_write) ? write_cmd : read_cmd;

    avm_address    = sel_cmd.address;
    avm_burstcount = sel_cmd.burstcount;
    avm_byteenable = sel_cmd.byteenable;
    avm_writedata  = sel_cmd.writedata;
    avm_read       = sel_cmd.read && (state_q == mem_bus_pkg::arb_idle ||
                                      state_q == mem_bus_pkg::arb_read_cmd);
    avm_write      = sel_cmd.write && (state_q == mem_bus_pkg::arb_idle ||
                                       state_q == mem_bus_pkg::arb_write);

    accept     = (avm_read || avm_write) && !avm_waitrequest;
    burst_len  = (state_q == mem_bus_pkg::arb_idle) ? sel_cmd.burstcount : burst_q;
    beat_event = (avm_write && !avm_waitrequest) ||
                 (state_q == mem_bus_pkg::arb_read_data && avm_readdatavalid);
    last       = beat_event && (beat_q + mem_cfg_pkg::one_beat == burst_len);
end

// responses only reach the owner
always_comb begin
    read_rsp  = '0;
    write_rsp = '0;
    if (owner == mem_bus_pkg::owner_read) begin
        read_rsp.accept = accept;
        read_rsp.valid  = (state_q == mem_bus_pkg::arb_read_data) && avm_readdatavalid;
        read_rsp.last   = last;
        read_rsp.data   = avm_readdata;
    end else begin
        write_rsp.accept = accept;
        write_rsp.last   = last;
    end
end

//--------------------------------------------------
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state_q <= mem_bus_pkg::arb_idle;
        owner_q <= mem_bus_pkg::owner_write;   // read engine wins the first tie
        beat_q  <= '0;
    end else begin
        if (last) begin
            beat_q <= '0;
        end else if (beat_event) begin
            beat_q <= beat_q + mem_cfg_pkg::one_beat;
        end

        case (state_q)
            mem_bus_pkg::arb_idle: begin
                if (read_cmd.read || write_cmd.write) begin
                    owner_q <= grant;
                end
                if (avm_read) begin
                    state_q <= accept ? mem_bus_pkg::arb_read_data : mem_bus_pkg::arb_read_cmd;
                end else if (avm_write && !last) begin
                    state_q <= mem_bus_pkg::arb_write;
                end
            end
            mem_bus_pkg::arb_read_cmd: begin
                if (accept) begin
                    state_q <= mem_bus_pkg::arb_read_data;
                end
            end
            mem_bus_pkg::arb_read_data, mem_bus_pkg::arb_write: begin
                if (last) begin
                    state_q <= mem_bus_pkg::arb_idle;
                end
            end
            default: state_q <= mem_bus_pkg::arb_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state_q == mem_bus_pkg::arb_idle) begin
        burst_q <= sel_cmd.burstcount;    // held for the whole burst
    end
end

endmodule

/* source/memory.sv */
/* memory port top level
 * read and write engines sharing one Avalon master through the arbiter */
`timescale 1ns/1ps

module memory (
    input  logic                                    clk,
    input  logic                                    arst_n,

    input  logic                                    read_do,
    input  logic [mem_cfg_pkg::addr_w-1:0]          read_address,
    input  logic [mem_cfg_pkg::read_len_w-1:0]      read_length,
    output logic                                    read_done,
    output logic [mem_cfg_pkg::read_data_w-1:0]     read_data,

    input  logic                                    write_do,
    input  logic [mem_cfg_pkg::addr_w-1:0]          write_address,
    input  logic [mem_cfg_pkg::write_len_w-1:0]     write_length,
    input  logic [mem_cfg_pkg::write_data_w-1:0]    write_data,
    output logic                                    write_done,

    // Avalon master
    output logic [mem_cfg_pkg::dword_addr_w-1:0]    avm_address,
    output logic [mem_cfg_pkg::burst_w-1:0]         avm_burstcount,
    output logic [mem_cfg_pkg::bytes_per_dword-1:0] avm_byteenable,
    output logic [mem_cfg_pkg::data_w-1:0]          avm_writedata,
    output logic                                    avm_read,
    output logic                                    avm_write,
    input  logic                                    avm_waitrequest,
    input  logic                                    avm_readdatavalid,
    input  logic [mem_cfg_pkg::data_w-1:0]          avm_readdata
);

mem_bus_pkg::bus_cmd_t read_cmd;
mem_bus_pkg::bus_cmd_t write_cmd;
mem_bus_pkg::bus_rsp_t read_rsp;
mem_bus_pkg::bus_rsp_t write_rsp;

//--------------------------------------------------
memory_read memory_read_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .read_do        (read_do),
    .read_address   (read_address),
    .read_length    (read_length),
    .read_done      (read_done),
    .read_data      (read_data),
    .cmd            (read_cmd),     // to arbiter
    .rsp            (read_rsp)
);

memory_write memory_write_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .write_do       (write_do),
    .write_address  (write_address),
    .write_length   (write_length),
    .write_data     (write_data),
    .write_done     (write_done),
    .cmd            (write_cmd),    // to arbiter
    .rsp            (write_rsp)
);

//--------------------------------------------------
avalon_arbiter avalon_arbiter_inst (
    .clk                (clk),
    .arst_n             (arst_n),
    .read_cmd           (read_cmd),
    .write_cmd          (write_cmd),
    .read_rsp           (read_rsp),
    .write_rsp          (write_rsp),
    .avm_address        (avm_address),
    .avm_burstcount     (avm_burstcount),
    .avm_byteenable     (avm_byteenable),
    .avm_writedata      (avm_writedata),
    .avm_read           (avm_read),
    .avm_write          (avm_write),
    .avm_waitrequest    (avm_waitrequest),
    .avm_readdatavalid  (avm_readdatavalid),
    .avm_readdata       (avm_readdata)
);

endmodule

/* verification/tb_clock_gen.sv */
/* testbench clock and reset
 * 4 ns clock, reset held low for the first five cycles */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    #20 arst_n = 1'b1;    // released on the fifth falling edge
end

always #2 clk = ~clk;     // 4 ns period

endmodule

/* verification/memory_tb.sv */
/* memory port testbench
 * Avalon memory model with random stalls, byte shadow for expected reads, checks and watchdog */
`timescale 1ns/1ps

module memory_tb;

logic                                    clk;
logic                                    arst_n;
logic                                    read_do = 1'b0;
logic [mem_cfg_pkg::addr_w-1:0]          read_address = '0;
logic [mem_cfg_pkg::read_len_w-1:0]      read_length = '0;
logic                                    read_done;
logic [mem_cfg_pkg::read_data_w-1:0]     read_data;
logic                                    write_do = 1'b0;
logic [mem_cfg_pkg::addr_w-1:0]          write_address = '0;
logic [mem_cfg_pkg::write_len_w-1:0]     write_length = '0;
logic [mem_cfg_pkg::write_data_w-1:0]    write_data = '0;
logic                                    write_done;
logic [mem_cfg_pkg::dword_addr_w-1:0]    avm_address;
logic [mem_cfg_pkg::burst_w-1:0]         avm_burstcount;
logic [mem_cfg_pkg::bytes_per_dword-1:0] avm_byteenable;
logic [mem_cfg_pkg::data_w-1:0]          avm_writedata;
logic                                    avm_read;
logic                                    avm_write;
logic                                    avm_waitrequest = 1'b0;
logic                                    avm_readdatavalid = 1'b0;
logic [mem_cfg_pkg::data_w-1:0]          avm_readdata = '0;

//--------------------------------------------------
// memory model state
logic [31:0] storage [256];
logic [7:0]  shadow [1024];      // byte view kept from the requests
int          rd_left = 0;
int          rd_delay = 0;
logic [7:0]  rd_ptr = '0;
int          wr_beat = 0;
int          wr_total = 0;
logic [7:0]  wr_base = '0;
logic [7:0]  wr_idx;
logic [31:0] wr_mask;
logic [3:0]  exp_be;
logic        held_q = 1'b0;
logic        seen_first = 1'b0;
mem_bus_pkg::owner_e   first_owner = mem_bus_pkg::owner_write;
mem_bus_pkg::bus_cmd_t held_cmd = '0;
mem_bus_pkg::bus_cmd_t cmd_now;

logic [63:0] exp_log [128];
string       name_log [128];
int          issued = 0;
int          checked = 0;
string       test_name = "reset";
int          bus_errs = 0;
int          data_errs = 0;
int          flow_errs = 0;
int          rand_reads = 40;
int          rand_writes = 30;

tb_clock_gen clock_gen_inst (.clk(clk), .arst_n(arst_n));

memory u_memory (.*);

//--------------------------------------------------
// byte i of the result is memory byte addr + i with higher bytes zero
function automatic logic [63:0] expected_read(input logic [31:0] addr, input int len);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < len; i++) begin
        value = value | (64'(shadow[10'(addr + 32'(i))]) << (8 * i));
    end
    return value;
endfunction

function automatic int dword_count(input logic [31:0] addr, input int len);
    return (int'(addr[1:0]) + len + 3) / 4;
endfunction

function automatic logic [3:0] expected_be(input logic [31:0] addr, input int len, input int beat);
    logic [3:0] be;
    int         pos;
    be = '0;
    for (int j = 0; j < 4; j++) begin
        pos = beat * 4 + j - int'(addr[1:0]);    // byte index within the write
        be  = be | (4'(pos >= 0 && pos < len) << j);
    end
    return be;
endfunction

task automatic start_read(input logic [31:0] addr, input int len);
    read_do                = 1'b1;
    read_address           = addr;
    read_length            = 4'(len);
    exp_log[7'(issued)]    = expected_read(addr, len);
    name_log[7'(issued)]   = test_name;
    issued++;
endtask

task automatic start_write(input logic [31:0] addr, input int len, input logic [31:0] data);
    write_do      = 1'b1;
    write_address = addr;
    write_length  = 3'(len);
    write_data    = data;
    for (int i = 0; i < len; i++) begin
        shadow[10'(addr + 32'(i))] = 8'(data >> (8 * i));
    end
endtask

// hold each request until its done pulse
task automatic finish_requests();
    while (read_do || write_do) begin
        @(negedge clk);
        if (read_done) begin
            read_do = 1'b0;
        end
        if (write_done) begin
            write_do = 1'b0;
        end
    end
endtask

//--------------------------------------------------
// Avalon slave sampled on the rising edge
always @(posedge clk) begin
    if (arst_n) begin
        cmd_now = {avm_read, avm_write, avm_address, avm_burstcount, avm_byteenable,
                   avm_writedata};
        assert (!(avm_read && avm_write)) else begin
            $display("avm_read and avm_write were high together at %0t", $time);
            bus_errs++;
        end
        if (held_q) begin
            assert (cmd_now == held_cmd) else begin
                $display("command changed while avm_waitrequest was high at %0t", $time);
                bus_errs++;
            end
        end
        held_q   = (avm_read || avm_write) && avm_waitrequest;
        held_cmd = cmd_now;

        if (avm_readdatavalid) begin
            rd_ptr  = rd_ptr + 8'd1;
            rd_left = rd_left - 1;
        end else if (rd_left != 0 && rd_delay > 1) begin
            rd_delay = rd_delay - 1;
        end

        if (avm_read && !avm_waitrequest) begin
            if (!seen_first) begin
                seen_first  = 1'b1;
                first_owner = mem_bus_pkg::owner_read;
            end
            assert (int'(avm_burstcount) == dword_count(read_address, int'(read_length))) else begin
                $display("FAILED %s burst count: expected %0d actual %0d", test_name,
                         dword_count(read_address, int'(read_length)), avm_burstcount);
                bus_errs++;
            end
            assert (avm_address == read_address[31:2]) else begin
                $display("FAILED %s address: expected %h actual %h", test_name,
                         read_address[31:2], avm_address);
                bus_errs++;
            end
            rd_ptr   = avm_address[7:0];
            rd_left  = int'(avm_burstcount);
            rd_delay = $urandom_range(1, 3);
        end

        if (avm_write && !avm_waitrequest) begin
            if (!seen_first) begin
                seen_first  = 1'b1;
                first_owner = mem_bus_pkg::owner_write;
            end
            if (wr_beat == 0) begin
                wr_base  = avm_address[7:0];
                wr_total = int'(avm_burstcount);
                assert (wr_total == dword_count(write_address, int'(write_length))) else begin
                    $display("FAILED %s burst count: expected %0d actual %0d", test_name,
                             dword_count(write_address, int'(write_length)), wr_total);
                    bus_errs++;
                end
            end
            exp_be = expected_be(write_address, int'(write_length), wr_beat);
            assert (avm_byteenable == exp_be) else begin
                $display("FAILED %s byte enable beat %0d: expected %b actual %b", test_name,
                         wr_beat, exp_be, avm_byteenable);
                bus_errs++;
            end
            wr_mask = {{8{avm_byteenable[3]}}, {8{avm_byteenable[2]}},
                       {8{avm_byteenable[1]}}, {8{avm_byteenable[0]}}};
            wr_idx  = 8'(int'(wr_base) + wr_beat);
            storage[wr_idx] = (storage[wr_idx] & ~wr_mask) | (avm_writedata & wr_mask);
            wr_beat = wr_beat + 1;
            if (wr_beat >= wr_total) begin
                wr_beat = 0;
            end
        end
    end
end

always @(negedge clk) begin
    avm_waitrequest   = arst_n && ($urandom_range(0, 3) == 0);   // stall about one in four
    avm_readdatavalid = (rd_left != 0) && (rd_delay <= 1);
    avm_readdata      = storage[rd_ptr];
end

// compare each returned read against its request
always @(negedge clk) begin
    if (arst_n && read_done) begin
        assert (checked < issued) else begin
            $display("read_done pulsed with no read pending at %0t", $time);
            data_errs++;
        end
        if (checked < issued) begin
            assert (read_data == exp_log[7'(checked)]) else begin
                $display("FAILED %s: expected %h actual %h", name_log[7'(checked)],
                         exp_log[7'(checked)], read_data);
                data_errs++;
            end
            checked++;
        end
    end
end

//--------------------------------------------------
initial begin
    logic [31:0] addr;
    int          len;
    void'($urandom(32'he854));
    for (int i = 0; i < 256; i++) begin
        storage[8'(i)] = $urandom;
        for (int j = 0; j < 4; j++) begin
            shadow[10'(i * 4 + j)] = 8'(storage[8'(i)] >> (8 * j));
        end
    end
    @(posedge arst_n);
    @(negedge clk);
    assert ({read_done, write_done, avm_read, avm_write} == 4'b0000) else begin
        $display("FAILED reset: expected 0000 actual %b",
                 {read_done, write_done, avm_read, avm_write});
        flow_errs++;
    end

    // both engines raised on one edge to different dwords
    test_name = "concurrent";
    start_read(32'h10, 4);
    start_write(32'h40, 4, $urandom);
    finish_requests();
    assert (seen_first && first_owner == mem_bus_pkg::owner_read) else begin
        $display("FAILED concurrent first grant: expected owner_read actual %s",
                 seen_first ? first_owner.name() : "none");
        flow_errs++;
    end
    start_read(32'h40, 4);
    finish_requests();

    test_name = "aligned";
    for (int n = 1; n <= 4; n++) begin
        start_read(32'($urandom_range(0, 255)) << 2, n);
        finish_requests();
    end

    test_name = "unaligned read";
    start_read(32'h23, 8);   // spans three dwords
    finish_requests();
    for (int n = 0; n < rand_reads; n++) begin
        start_read($urandom_range(0, 1023), $urandom_range(1, 8));
        finish_requests();
    end

    for (int n = 0; n < rand_writes; n++) begin
        addr      = $urandom_range(0, 1023);
        len       = $urandom_range(1, 4);
        test_name = "write";
        start_write(addr, len, $urandom);
        finish_requests();
        test_name = "write readback";
        start_read(addr, len);
        finish_requests();
    end

    repeat (2) @(negedge clk);
    assert (checked == issued) else begin
        $display("%0d reads never returned data", issued - checked);
        flow_errs++;
    end
    $display("errors: %0d bus, %0d data, %0d flow", bus_errs, data_errs, flow_errs);
    if (bus_errs + data_errs + flow_errs == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

// 40 cycles per request plus reset and drain
initial begin
    repeat (40 * (8 + rand_reads + 2 * rand_writes) + 100) @(posedge clk);
    $display("watchdog expired with requests still open");
    $display("Something failed");
    $finish;
end

endmodule

/* compile.f */
source/mem_cfg_pkg.sv
source/mem_bus_pkg.sv
source/memory_read.sv
source/memory_write.sv
source/avalon_arbiter.sv
source/memory.sv
verification/tb_clock_gen.sv
verification/memory_tb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the memory port testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module memory_tb -f compile.f -o memory_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/memory_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
